//--- snoop_pkg.sv
package snoop_pkg;

    // Cache geometry
    localparam int unsigned SET_W         = 6;
    localparam int unsigned TAG_W         = 20;
    localparam int unsigned WAYS          = 4;
    localparam int unsigned ACCESS_W      = 64;
    localparam int unsigned LINE_ACCESSES = 4;
    localparam int unsigned WORD_W        = 2;

    // Response buffering
    localparam int unsigned DATA_FIFO_DEPTH = 4;
    localparam int unsigned META_FIFO_DEPTH = 1;

    typedef logic [SET_W-1:0]    set_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [WAYS-1:0]     way_vec_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [ACCESS_W-1:0] access_data_t;

    // Snoop operation, exactly one flag set
    typedef struct packed {
        logic read_clean;
        logic read_not_shared_dirty;
        logic read_once;
        logic read_shared;
        logic read_unique;
        logic clean_invalid;
        logic clean_shared;
        logic make_invalid;
    } snoop_op_t;

    // Directory state of one cache line
    typedef struct packed {
        logic valid;
        logic wback;
        logic dirty;
        logic shared;
        logic fetch;
    } dir_state_t;

    typedef struct packed {
        snoop_op_t  op;
        set_t       set;
        tag_t       tag;
        way_vec_t   way;
        dir_state_t dir;
    } snoop_req_t;

    // Metadata returned for every snoop
    typedef struct packed {
        logic was_unique;
        logic is_shared;
        logic pass_dirty;
        logic left_dirty;
        logic data_transfer;
    } snoop_meta_t;

    // What the sequencer has to do for one request
    typedef struct packed {
        snoop_meta_t meta;
        logic        read_data;
        logic        updt_dir;
        dir_state_t  new_dir;
    } snoop_plan_t;

    typedef struct packed {
        set_t     set;
        way_vec_t way;
        word_t    word;
    } data_read_t;

    typedef struct packed {
        set_t       set;
        way_vec_t   way;
        tag_t       tag;
        dir_state_t state;
    } dir_updt_t;

    // One beat of line data
    typedef struct packed {
        access_data_t data;
        logic         last;
    } snoop_data_t;

endpackage

//--- snoop_decode.sv
module snoop_decode (
    input  snoop_pkg::snoop_req_t  req_i,
    output snoop_pkg::snoop_plan_t plan_o
);

    import snoop_pkg::*;

    snoop_op_t  op;
    dir_state_t dir;

    assign op  = req_i.op;
    assign dir = req_i.dir;

    always_comb begin
        plan_o = '0;

        // An invalid line gets an all-zero response and no action
        if (dir.valid) begin
            plan_o.meta.was_unique = !dir.shared;

            unique case (1'b1)
                op.read_clean,
                op.read_not_shared_dirty,
                op.read_shared: begin
                    // Line stays valid but becomes shared
                    plan_o.meta.is_shared     = 1'b1;
                    plan_o.meta.left_dirty    = dir.dirty;
                    plan_o.meta.data_transfer = 1'b1;
                    plan_o.updt_dir           = 1'b1;
                    plan_o.new_dir            = dir;
                    plan_o.new_dir.shared     = 1'b1;
                end

                op.read_once: begin
                    // Directory is left as it is
                    plan_o.meta.is_shared     = 1'b1;
                    plan_o.meta.left_dirty    = dir.dirty;
                    plan_o.meta.data_transfer = 1'b1;
                end

                op.read_unique: begin
                    plan_o.meta.pass_dirty    = dir.dirty;
                    plan_o.meta.data_transfer = 1'b1;
                    plan_o.updt_dir           = 1'b1;
                end

                op.clean_invalid: begin
                    // Data only moves when there is something to write back
                    plan_o.meta.pass_dirty    = dir.dirty;
                    plan_o.meta.data_transfer = dir.dirty;
                    plan_o.updt_dir           = 1'b1;
                end

                op.clean_shared: begin
                    plan_o.meta.is_shared     = 1'b1;
                    plan_o.meta.pass_dirty    = dir.dirty;
                    plan_o.meta.data_transfer = dir.dirty;
                    plan_o.updt_dir           = 1'b1;
                    plan_o.new_dir            = dir;
                    plan_o.new_dir.dirty      = 1'b0;
                end

                op.make_invalid: begin
                    plan_o.updt_dir = 1'b1;
                end

                default: begin
                    plan_o.meta = '0;
                end
            endcase
        end

        plan_o.read_data = plan_o.meta.data_transfer;
    end

endmodule

//--- snoop_seq.sv
module snoop_seq (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // Snoop request
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  snoop_pkg::snoop_req_t          req_i,
    input  snoop_pkg::snoop_plan_t         plan_i,

    // Response FIFO write side
    input  logic                           meta_wok_i,
    output logic                           meta_w_o,
    output snoop_pkg::snoop_meta_t         meta_wdata_o,
    input  logic                           data_wok_i,
    output logic                           data_w_o,
    output snoop_pkg::snoop_data_t         data_wdata_o,

    // Cache data array
    output logic                           data_read_o,
    output snoop_pkg::data_read_t          data_read_addr_o,
    input  logic [snoop_pkg::ACCESS_W-1:0] data_read_data_i,

    // Cache directory
    output logic                           dir_updt_o,
    output snoop_pkg::dir_updt_t           dir_updt_data_o
);

    import snoop_pkg::*;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_READ_FIRST,
        SEQ_READ_NEXT,
        SEQ_DIR_UPDT
    } seq_state_e;

    seq_state_e state_q, state_d;
    word_t      word_q, word_d;
    logic       updt_dir_q;
    logic       accept;
    logic       data_eol;

    set_t       req_set_q;
    tag_t       req_tag_q;
    way_vec_t   req_way_q;
    dir_state_t new_dir_q;

    assign req_ready_o = (state_q == SEQ_IDLE) && meta_wok_i;
    assign accept      = req_valid_i && req_ready_o;

    // Counter has wrapped back to zero once the last word was read
    assign data_eol = (word_q == '0);

    // Metadata is known at acceptance
    assign meta_w_o     = accept;
    assign meta_wdata_o = plan_i.meta;

    // Array data arrives one cycle after its read strobe
    assign data_wdata_o = '{data: data_read_data_i, last: data_eol};

    always_comb begin
        state_d     = state_q;
        word_d      = word_q;
        data_read_o = 1'b0;
        data_w_o    = 1'b0;
        dir_updt_o  = 1'b0;

        case (state_q)
            SEQ_IDLE: begin
                if (accept) begin
                    if (plan_i.read_data) begin
                        state_d = SEQ_READ_FIRST;
                    end else if (plan_i.updt_dir) begin
                        state_d = SEQ_DIR_UPDT;
                    end
                end
            end

            SEQ_READ_FIRST: begin
                if (data_wok_i) begin
                    data_read_o = 1'b1;
                    word_d      = word_q + 1'b1;
                    state_d     = SEQ_READ_NEXT;
                end
            end

            SEQ_READ_NEXT: begin
                // Push the previous word, read the next one unless the line is done
                if (data_wok_i) begin
                    data_w_o    = 1'b1;
                    data_read_o = !data_eol;
                    if (data_eol) begin
                        state_d = updt_dir_q ? SEQ_DIR_UPDT : SEQ_IDLE;
                    end else begin
                        // Wraps to zero after the last word of the line
                        word_d = word_q + 1'b1;
                    end
                end
            end

            SEQ_DIR_UPDT: begin
                dir_updt_o = 1'b1;
                state_d    = SEQ_IDLE;
            end

            default: begin
                state_d = SEQ_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= SEQ_IDLE;
            word_q     <= '0;
            updt_dir_q <= 1'b0;
        end else begin
            state_q <= state_d;
            word_q  <= word_d;
            if (accept) begin
                updt_dir_q <= plan_i.updt_dir;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_set_q <= req_i.set;
            req_tag_q <= req_i.tag;
            req_way_q <= req_i.way;
            new_dir_q <= plan_i.new_dir;
        end
    end

    assign data_read_addr_o = '{set: req_set_q, way: req_way_q, word: word_q};

    assign dir_updt_data_o = '{
        set:   req_set_q,
        way:   req_way_q,
        tag:   req_tag_q,
        state: new_dir_q
    };

endmodule

//--- snoop_rsp_fifo.sv
module snoop_rsp_fifo #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 2
) (
    input  logic     clk_i,
    input  logic     rst_ni,

    input  logic     w_i,
    output logic     wok_o,
    input  payload_t wdata_i,

    input  logic     r_i,
    output logic     rok_o,
    output payload_t rdata_o
);

    // A single entry still needs a one-bit pointer
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               push;
    logic               pop;

    assign wok_o   = (count_q != CNT_W'(DEPTH));
    assign rok_o   = (count_q != '0);
    assign rdata_o = mem[rd_ptr_q];

    assign push = w_i && wok_o;
    assign pop  = r_i && rok_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // Simultaneous push and pop leave the count unchanged
            if (push && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q] <= wdata_i;
        end
    end

endmodule

//--- snoop_handler.sv
module snoop_handler (
    input  logic                           clk_i,
    input  logic                           rst_ni,

    // Snoop request
    input  logic                           req_valid_i,
    output logic                           req_ready_o,
    input  snoop_pkg::snoop_req_t          req_i,

    // Cache data array
    output logic                           data_read_o,
    output snoop_pkg::data_read_t          data_read_addr_o,
    input  logic [snoop_pkg::ACCESS_W-1:0] data_read_data_i,

    // Cache directory
    output logic                           dir_updt_o,
    output snoop_pkg::dir_updt_t           dir_updt_data_o,

    // Metadata response
    output logic                           meta_valid_o,
    output snoop_pkg::snoop_meta_t         meta_o,
    input  logic                           meta_ready_i,

    // Data response
    output logic                           data_valid_o,
    output snoop_pkg::snoop_data_t         data_o,
    input  logic                           data_ready_i
);

    import snoop_pkg::*;

    snoop_plan_t plan;
    logic        meta_w;
    logic        meta_wok;
    snoop_meta_t meta_wdata;
    logic        data_w;
    logic        data_wok;
    snoop_data_t data_wdata;

    snoop_decode u_decode (
        .req_i  (req_i),
        .plan_o (plan)
    );

    snoop_seq u_seq (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_i            (req_i),
        .plan_i           (plan),
        .meta_wok_i       (meta_wok),
        .meta_w_o         (meta_w),
        .meta_wdata_o     (meta_wdata),
        .data_wok_i       (data_wok),
        .data_w_o         (data_w),
        .data_wdata_o     (data_wdata),
        .data_read_o      (data_read_o),
        .data_read_addr_o (data_read_addr_o),
        .data_read_data_i (data_read_data_i),
        .dir_updt_o       (dir_updt_o),
        .dir_updt_data_o  (dir_updt_data_o)
    );

    // One metadata entry per accepted request
    snoop_rsp_fifo #(
        .payload_t (snoop_meta_t),
        .DEPTH     (META_FIFO_DEPTH)
    ) u_meta_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (meta_w),
        .wok_o   (meta_wok),
        .wdata_i (meta_wdata),
        .r_i     (meta_ready_i),
        .rok_o   (meta_valid_o),
        .rdata_o (meta_o)
    );

    snoop_rsp_fifo #(
        .payload_t (snoop_data_t),
        .DEPTH     (DATA_FIFO_DEPTH)
    ) u_data_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .w_i     (data_w),
        .wok_o   (data_wok),
        .wdata_i (data_wdata),
        .r_i     (data_ready_i),
        .rok_o   (data_valid_o),
        .rdata_o (data_o)
    );

endmodule

//--- snoop_handler_properties.sv
module snoop_handler_properties (
    input logic                   clk_i,
    input logic                   rst_ni,
    input logic                   req_ready_o,
    input logic                   data_read_o,
    input logic                   dir_updt_o,
    input logic                   meta_valid_o,
    input logic                   meta_ready_i,
    input snoop_pkg::snoop_meta_t meta_o
);

    // The word read in one cycle is still pushed in the next,
    // so no directory write may come in either of them
    property no_read_with_dir_updt;
        @(posedge clk_i) disable iff (!rst_ni)
            data_read_o |-> !dir_updt_o ##1 !dir_updt_o;
    endproperty

    // No new request while a line is still being read or pushed
    property no_ready_while_reading;
        @(posedge clk_i) disable iff (!rst_ni)
            data_read_o |-> !req_ready_o ##1 !req_ready_o;
    endproperty

    // Stalled metadata must not change
    property meta_stable_when_stalled;
        @(posedge clk_i) disable iff (!rst_ni)
            (meta_valid_o && !meta_ready_i) |=> $stable(meta_o);
    endproperty

    read_dir_exclusive: assert property (no_read_with_dir_updt)
        else $error("Array read and directory write too close together");

    ready_low_on_read: assert property (no_ready_while_reading)
        else $error("Request ready high while a line is being read");

    meta_held: assert property (meta_stable_when_stalled)
        else $error("Metadata changed while waiting for ready");

endmodule

bind snoop_handler snoop_handler_properties props_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .req_ready_o  (req_ready_o),
    .data_read_o  (data_read_o),
    .dir_updt_o   (dir_updt_o),
    .meta_valid_o (meta_valid_o),
    .meta_ready_i (meta_ready_i),
    .meta_o       (meta_o)
);

//--- tb_snoop_handler.sv
module tb_snoop_handler;

    import snoop_pkg::*;

    localparam int NUM_REQS     = 300;
    localparam int CLK_PERIOD   = 20;
    localparam int DRAIN_CYCLES = 200;
    localparam int TIMEOUT      = NUM_REQS * (LINE_ACCESSES + 8) * CLK_PERIOD;

    logic         clk_i;
    logic         rst_ni;
    logic         req_valid_i;
    logic         req_ready_o;
    snoop_req_t   req_i;
    logic         data_read_o;
    data_read_t   data_read_addr_o;
    access_data_t data_read_data_i;
    logic         dir_updt_o;
    dir_updt_t    dir_updt_data_o;
    logic         meta_valid_o;
    snoop_meta_t  meta_o;
    logic         meta_ready_i;
    logic         data_valid_o;
    snoop_data_t  data_o;
    logic         data_ready_i;

    int           seed;
    int           accepted;
    int           drain;
    logic         req_taken;
    logic         rd_pending;
    data_read_t   rd_addr;

    snoop_meta_t  exp_meta_q[$];
    snoop_data_t  exp_data_q[$];
    dir_updt_t    exp_dir_q[$];

    snoop_handler dut_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_ready_o      (req_ready_o),
        .req_i            (req_i),
        .data_read_o      (data_read_o),
        .data_read_addr_o (data_read_addr_o),
        .data_read_data_i (data_read_data_i),
        .dir_updt_o       (dir_updt_o),
        .dir_updt_data_o  (dir_updt_data_o),
        .meta_valid_o     (meta_valid_o),
        .meta_o           (meta_o),
        .meta_ready_i     (meta_ready_i),
        .data_valid_o     (data_valid_o),
        .data_o           (data_o),
        .data_ready_i     (data_ready_i)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic stop_on_error();
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped after an error");
    endtask

    // Array contents depend on set, way and word together
    function automatic access_data_t array_word(set_t s, way_vec_t w, word_t i);
        logic [11:0] key;
        key = {s, w, i};
        return {4'h9, key, ~key, key ^ 12'h5a3, {key[5:0], key[11:6]}, key + 12'd77};
    endfunction

    function automatic snoop_req_t random_request();
        snoop_req_t r;
        logic [7:0] op_bits;
        int         idx;
        op_bits      = '0;
        idx          = $unsigned($random(seed)) % 8;
        op_bits[idx] = 1'b1;
        r.op         = op_bits;
        r.set        = set_t'($random(seed));
        r.tag        = tag_t'($random(seed));
        r.way        = '0;
        idx          = $unsigned($random(seed)) % WAYS;
        r.way[idx]   = 1'b1;
        r.dir        = dir_state_t'($random(seed));
        // Mostly valid lines, so that most requests do some work
        r.dir.valid  = ($unsigned($random(seed)) % 4) != 0;
        return r;
    endfunction

    // Expected responses for one accepted request
    task automatic model_request(input snoop_req_t r);
        snoop_op_t   op;
        dir_state_t  d;
        snoop_meta_t m;
        snoop_data_t beat;
        dir_updt_t   u;
        logic        keep_shared;
        logic        clean_op;
        int          i;
        op          = r.op;
        d           = r.dir;
        m           = '0;
        keep_shared = op.read_clean | op.read_not_shared_dirty | op.read_shared | op.read_once;
        clean_op    = op.clean_invalid | op.clean_shared;
        if (d.valid) begin
            m.was_unique    = !d.shared;
            m.is_shared     = keep_shared | op.clean_shared;
            m.pass_dirty    = (op.read_unique | clean_op) & d.dirty;
            m.left_dirty    = keep_shared & d.dirty;
            m.data_transfer = keep_shared | op.read_unique | (clean_op & d.dirty);
        end
        exp_meta_q.push_back(m);
        if (m.data_transfer) begin
            for (i = 0; i < LINE_ACCESSES; i++) begin
                beat.data = array_word(r.set, r.way, word_t'(i));
                beat.last = (i == LINE_ACCESSES - 1);
                exp_data_q.push_back(beat);
            end
        end
        if (d.valid && !op.read_once) begin
            u = '{set: r.set, way: r.way, tag: r.tag, state: '0};
            if (keep_shared) begin
                u.state        = d;
                u.state.shared = 1'b1;
            end else if (op.clean_shared) begin
                u.state       = d;
                u.state.dirty = 1'b0;
            end
            exp_dir_q.push_back(u);
        end
    endtask

    task automatic check_meta(input snoop_meta_t got, input snoop_meta_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: metadata %b, expected %b", $time, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_data(input snoop_data_t got, input snoop_data_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: data beat %h/%b, expected %h/%b",
                     $time, got.data, got.last, exp.data, exp.last);
            stop_on_error();
        end
    endtask

    task automatic check_dir(input dir_updt_t got, input dir_updt_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: directory write %h, expected %h", $time, got, exp);
            stop_on_error();
        end
    endtask

    // Called at the falling edge, where all outputs are settled
    task automatic sample_outputs();
        if (req_valid_i && req_ready_o) begin
            model_request(req_i);
            accepted++;
            req_taken = 1'b1;
        end
        if (meta_valid_o && meta_ready_i) begin
            if (exp_meta_q.size() == 0) begin
                $display("Metadata response at %0t without a matching request", $time);
                stop_on_error();
            end else begin
                check_meta(meta_o, exp_meta_q.pop_front());
            end
        end
        if (data_valid_o && data_ready_i) begin
            if (exp_data_q.size() == 0) begin
                $display("Data beat at %0t that no request asked for", $time);
                stop_on_error();
            end else begin
                check_data(data_o, exp_data_q.pop_front());
            end
        end
        if (dir_updt_o) begin
            if (exp_dir_q.size() == 0) begin
                $display("Directory write at %0t that no request asked for", $time);
                stop_on_error();
            end else begin
                check_dir(dir_updt_data_o, exp_dir_q.pop_front());
            end
        end
        if (data_read_o) begin
            rd_addr    = data_read_addr_o;
            rd_pending = 1'b1;
        end
    endtask

    task automatic drive_inputs();
        // Array answers the previous strobe and then holds its data
        if (rd_pending) begin
            data_read_data_i = array_word(rd_addr.set, rd_addr.way, rd_addr.word);
            rd_pending       = 1'b0;
        end
        if (!req_valid_i || req_taken) begin
            if (accepted < NUM_REQS && ($unsigned($random(seed)) % 4) != 0) begin
                req_valid_i = 1'b1;
                req_i       = random_request();
            end else begin
                req_valid_i = 1'b0;
            end
        end
        req_taken    = 1'b0;
        meta_ready_i = ($unsigned($random(seed)) % 10) < 7;
        data_ready_i = ($unsigned($random(seed)) % 10) < 7;
    endtask

    task automatic step_cycle();
        sample_outputs();
        @(posedge clk_i);
        #2;
        drive_inputs();
        @(negedge clk_i);
    endtask

    initial begin
        #(TIMEOUT);
        $display("Timeout: the test did not finish within %0d time units", TIMEOUT);
        stop_on_error();
    end

    initial begin
        seed             = 32'h4f55116c;
        clk_i            = 1'b0;
        rst_ni           = 1'b0;
        req_valid_i      = 1'b0;
        req_i            = '0;
        data_read_data_i = '0;
        meta_ready_i     = 1'b0;
        data_ready_i     = 1'b0;
        accepted         = 0;
        req_taken        = 1'b0;
        rd_pending       = 1'b0;
        rd_addr          = '0;

        repeat (5) begin
            @(negedge clk_i);
            if (data_read_o || dir_updt_o || meta_valid_o || data_valid_o) begin
                $display("Control outputs are not low during reset");
                stop_on_error();
            end
        end
        @(posedge clk_i);
        #2;
        rst_ni      = 1'b1;
        req_valid_i = 1'b1;
        req_i       = random_request();
        @(negedge clk_i);
        if (!req_ready_o) begin
            $display("First request after reset was not accepted");
            stop_on_error();
        end

        while (accepted < NUM_REQS) begin
            step_cycle();
        end

        // Let the FIFOs and the sequencer drain, then look for stray responses
        drain = 0;
        while ((exp_meta_q.size() != 0 || exp_data_q.size() != 0 || exp_dir_q.size() != 0)
               && drain < DRAIN_CYCLES) begin
            step_cycle();
            drain++;
        end
        repeat (10) begin
            step_cycle();
        end

        if (exp_meta_q.size() != 0 || exp_data_q.size() != 0 || exp_dir_q.size() != 0) begin
            $display("Responses still missing at the end of the test");
            stop_on_error();
        end else begin
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

//--- flist.f
snoop_pkg.sv
snoop_decode.sv
snoop_seq.sv
snoop_rsp_fifo.sv
snoop_handler.sv
snoop_handler_properties.sv
tb_snoop_handler.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_snoop_handler
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing --assert -Wno-fatal \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q ">>> PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
